// ==== rtl/srcPkg.sv ====
package srcPkg;

    localparam int wordW = 32;                     // data and bus width.
    localparam int memAddrW = 9;                   // word address bits.
    localparam int memDepth = 1 << memAddrW;       // 512 words.

    typedef logic [wordW-1:0] wordT;               // bus and register word.
    typedef logic [3:0] regIdxT;                   // R0..R15.
    typedef logic [memAddrW-1:0] memAddrT;         // RAM word address.

    typedef enum logic [4:0] {
        opLd   = 5'b00000,
        opLdi  = 5'b00001,
        opSt   = 5'b00010,
        opAdd  = 5'b00011,
        opSub  = 5'b00100,
        opAnd  = 5'b00101,
        opOr   = 5'b00110,
        opAddi = 5'b01100,
        opBr   = 5'b10010,
        opJr   = 5'b10100,
        opJal  = 5'b10101,
        opIn   = 5'b10110,
        opOut  = 5'b10111,
        opNop  = 5'b11010,
        opHalt = 5'b11011
    } opcodeT;                                     // unlisted codes run as nop.

    typedef enum logic [2:0] {
        aluAdd,
        aluSub,
        aluAnd,
        aluOr,
        aluIncPc                                   // bus plus one.
    } aluOpT;

    typedef enum logic [2:0] {
        busNone,
        busPc,
        busMdr,
        busZLow,
        busReg,
        busInPort,
        busConst
    } busSrcT;

    typedef enum logic [4:0] {
        sReset, sT0, sT1, sWait1, sWait2, sT2,
        sT3, sT4, sT5, sT6, sT7,
        sWait3, sWait4, sHalt
    } seqStateT;

    typedef struct packed {
        busSrcT busSel;                            // single bus driver.
        logic gra;                                 // select by ra field.
        logic grb;                                 // select by rb field.
        logic grc;                                 // select by rc field.
        logic rIn;                                 // write selected reg.
        logic baOut;                               // R0 reads zero.
        logic jalR15;                              // link write.
        logic pcIn;
        logic irIn;
        logic yIn;
        logic zIn;
        logic marIn;
        logic mdrIn;
        logic conIn;                               // evaluate branch cond.
        logic outPortIn;
        aluOpT aluOp;
        logic memRead;
        logic memWrite;
    } ctrlT;

    typedef struct packed {
        opcodeT opcode;                            // current instruction.
        logic conFlag;                             // branch condition result.
    } statusT;

endpackage

// ==== rtl/registerFile.sv ====
`timescale 1ns/10ps

module registerFile (
    input  logic         clock,
    input  logic         rstN,
    input  srcPkg::ctrlT ctrl,
    input  srcPkg::wordT ir,
    input  srcPkg::wordT busWord,
    output srcPkg::wordT regOut
);
    import srcPkg::*;

    wordT   regs [16];                             // R0..R15.
    regIdxT selIdx;

    always_comb begin
        if (ctrl.gra) begin
            selIdx = ir[26:23];                    // ra field.
        end else if (ctrl.grb) begin
            selIdx = ir[22:19];                    // rb field.
        end else if (ctrl.grc) begin
            selIdx = ir[18:15];                    // rc field.
        end else begin
            selIdx = '0;
        end
    end

    // under base addressing R0 gives zero instead of its contents.
    assign regOut = (ctrl.baOut && selIdx == '0) ? '0 : regs[selIdx];

    always_ff @(posedge clock) begin
        if (!rstN) begin
            for (int i = 0; i < 16; i++) begin
                regs[i] <= '0;                     // all registers cleared.
            end
        end else begin
            if (ctrl.rIn) begin
                regs[selIdx] <= busWord;
            end
            if (ctrl.jalR15) begin
                regs[15] <= busWord;               // return address.
            end
        end
    end

endmodule

// ==== rtl/aluUnit.sv ====
`timescale 1ns/10ps

module aluUnit (
    input  logic         clock,
    input  logic         rstN,
    input  srcPkg::ctrlT ctrl,
    input  srcPkg::wordT busWord,
    output srcPkg::wordT zLow
);
    import srcPkg::*;

    wordT yReg;                                    // first operand.
    wordT zReg;                                    // result register.
    wordT result;

    always_comb begin
        case (ctrl.aluOp)
            aluAdd:   result = yReg + busWord;
            aluSub:   result = yReg - busWord;     // wraps at 32 bits.
            aluAnd:   result = yReg & busWord;
            aluOr:    result = yReg | busWord;
            aluIncPc: result = busWord + 32'd1;    // pc increment path.
            default:  result = yReg + busWord;
        endcase
    end

    always_ff @(posedge clock) begin
        if (!rstN) begin
            yReg <= '0;
            zReg <= '0;
        end else begin
            if (ctrl.yIn) begin
                yReg <= busWord;
            end
            if (ctrl.zIn) begin
                zReg <= result;
            end
        end
    end

    assign zLow = zReg;

endmodule

// ==== rtl/memoryInterface.sv ====
`timescale 1ns/10ps

module memoryInterface (
    input  logic            clock,
    input  logic            rstN,
    input  srcPkg::ctrlT    ctrl,
    input  srcPkg::wordT    busWord,
    output srcPkg::wordT    mdrWord,
    input  logic            progWrite,
    input  srcPkg::memAddrT progAddr,
    input  srcPkg::wordT    progData
);
    import srcPkg::*;

    wordT    ram [memDepth];                       // program and data words.
    memAddrT mar;
    wordT    mdr;
    memAddrT rdAddr;                               // address latched by memRead.
    wordT    rdData;                               // first read stage.
    logic    rdPend1;
    logic    rdPend2;

    // read request tracking.
    always_ff @(posedge clock) begin
        if (!rstN) begin
            rdPend1 <= 1'b0;
            rdPend2 <= 1'b0;
        end else begin
            rdPend1 <= ctrl.memRead;
            rdPend2 <= rdPend1;
        end
    end

    always_ff @(posedge clock) begin
        if (progWrite) begin
            ram[progAddr] <= progData;             // load port wins.
        end else if (ctrl.memWrite) begin
            ram[mar] <= mdr;
        end
    end

    always_ff @(posedge clock) begin
        if (ctrl.marIn) begin
            mar <= busWord[memAddrW-1:0];          // word address from bus.
        end
        if (ctrl.memRead) begin
            rdAddr <= mar;
        end
        if (rdPend1) begin
            rdData <= ram[rdAddr];
        end
        if (rdPend2) begin
            mdr <= rdData;                         // word ready after second wait.
        end else if (ctrl.mdrIn && !ctrl.memRead) begin
            mdr <= busWord;                        // store data path.
        end
    end

    assign mdrWord = mdr;

endmodule

// ==== rtl/miniSrcDatapath.sv ====
`timescale 1ns/10ps

module miniSrcDatapath (
    input  logic           clock,
    input  logic           rstN,
    input  srcPkg::ctrlT   ctrl,
    input  srcPkg::wordT   mdrWord,
    output srcPkg::wordT   busWord,
    output srcPkg::statusT status,
    input  logic           inStrobe,
    input  srcPkg::wordT   inPortData,
    output srcPkg::wordT   outPortData,
    output logic           outValid
);
    import srcPkg::*;

    wordT pc;
    wordT ir;
    wordT regOut;                                  // selected register.
    wordT zLow;
    wordT constWord;                               // sign-extended c field.
    wordT inPortReg;
    wordT outPortReg;
    logic conFlag;
    logic conEval;

    registerFile u_registerFile (
        .clock   (clock),
        .rstN    (rstN),
        .ctrl    (ctrl),
        .ir      (ir),
        .busWord (busWord),
        .regOut  (regOut)
    );

    aluUnit u_aluUnit (
        .clock   (clock),
        .rstN    (rstN),
        .ctrl    (ctrl),
        .busWord (busWord),
        .zLow    (zLow)
    );

    assign constWord = {{13{ir[18]}}, ir[18:0]};

    always_comb begin
        case (ctrl.busSel)
            busPc:     busWord = pc;
            busMdr:    busWord = mdrWord;
            busZLow:   busWord = zLow;
            busReg:    busWord = regOut;
            busInPort: busWord = inPortReg;
            busConst:  busWord = constWord;
            default:   busWord = '0;           // idle bus.
        endcase
    end

    always_comb begin
        case (ir[20:19])                           // c2 field.
            2'b00:   conEval = (busWord == '0);
            2'b01:   conEval = (busWord != '0);
            2'b10:   conEval = ~busWord[31];   // zero or positive.
            default: conEval = busWord[31];    // negative.
        endcase
    end

    always_ff @(posedge clock) begin
        if (!rstN) begin
            pc <= '0;
            ir <= {opNop, 27'd0};
            conFlag <= 1'b0;
            outValid <= 1'b0;
        end else begin
            if (ctrl.pcIn) begin
                pc <= busWord;
            end
            if (ctrl.irIn) begin
                ir <= busWord;
            end
            if (ctrl.conIn) begin
                conFlag <= conEval;
            end
            outValid <= ctrl.outPortIn;            // one-cycle strobe.
        end
    end

    always_ff @(posedge clock) begin
        if (inStrobe) begin
            inPortReg <= inPortData;               // last strobe wins.
        end
        if (ctrl.outPortIn) begin
            outPortReg <= busWord;
        end
    end

    assign outPortData = outPortReg;

    // during the IR load the opcode comes straight from the MDR, so the
    // sequencer can branch on it in the same cycle.
    assign status.opcode = opcodeT'(ctrl.irIn ? mdrWord[31:27] : ir[31:27]);
    assign status.conFlag = conFlag;

endmodule

// ==== rtl/controlSequencer.sv ====
`timescale 1ns/10ps

module controlSequencer (
    input  logic           clock,
    input  logic           rstN,
    input  srcPkg::statusT status,
    output srcPkg::ctrlT   ctrl,
    output logic           halted
);
    import srcPkg::*;

    seqStateT state;
    seqStateT stateNext;
    ctrlT     ctrlNext;                            // control for stateNext.
    aluOpT    regAluOp;                            // op of a register ALU instr.
    logic     isAluReg;
    logic     isImmOp;                             // addi or ldi.

    assign isAluReg = status.opcode inside {opAdd, opSub, opAnd, opOr};
    assign isImmOp  = status.opcode inside {opAddi, opLdi};

    always_comb begin
        case (status.opcode)
            opSub:   regAluOp = aluSub;
            opAnd:   regAluOp = aluAnd;
            opOr:    regAluOp = aluOr;
            default: regAluOp = aluAdd;
        endcase
    end

    always_comb begin
        stateNext = state;
        case (state)
            sReset: stateNext = sT0;
            sT0:    stateNext = sT1;
            sT1:    stateNext = sWait1;
            sWait1: stateNext = sWait2;
            sWait2: stateNext = sT2;
            sT2: begin
                if (status.opcode == opHalt) begin
                    stateNext = sHalt;
                end else if (status.opcode inside {opLd, opLdi, opSt, opAddi, opBr,
                                                   opJr, opJal, opIn, opOut} || isAluReg) begin
                    stateNext = sT3;
                end else begin
                    stateNext = sT0;               // nop and unknown codes.
                end
            end
            sT3: stateNext = (status.opcode inside {opJr, opIn, opOut}) ? sT0 : sT4;
            sT4: stateNext = (status.opcode == opJal) ? sT0 : sT5;
            sT5: stateNext = (isAluReg || isImmOp) ? sT0 : sT6;
            sT6: begin
                case (status.opcode)
                    opLd:    stateNext = sWait3;
                    opSt:    stateNext = sT7;
                    default: stateNext = sT0;      // br done.
                endcase
            end
            sWait3: stateNext = sWait4;
            sWait4: stateNext = sT7;
            sT7:    stateNext = sT0;
            sHalt:  stateNext = sHalt;             // until reset.
            default: stateNext = sReset;
        endcase
    end

    // control word for the state about to be entered.
    always_comb begin
        ctrlNext = '0;
        case (stateNext)
            sT0: begin
                ctrlNext.busSel = busPc;
                ctrlNext.marIn = 1'b1;
                ctrlNext.aluOp = aluIncPc;
                ctrlNext.zIn = 1'b1;
            end
            sT1: begin
                ctrlNext.busSel = busZLow;         // pc + 1 back to pc.
                ctrlNext.pcIn = 1'b1;
                ctrlNext.memRead = 1'b1;
            end
            sT2: begin
                ctrlNext.busSel = busMdr;
                ctrlNext.irIn = 1'b1;
            end
            sT3: begin
                case (status.opcode)
                    opBr: begin
                        ctrlNext.busSel = busReg;
                        ctrlNext.gra = 1'b1;
                        ctrlNext.conIn = 1'b1;     // test Ra.
                    end
                    opJr: begin
                        ctrlNext.busSel = busReg;
                        ctrlNext.gra = 1'b1;
                        ctrlNext.pcIn = 1'b1;
                    end
                    opJal: begin
                        ctrlNext.busSel = busPc;
                        ctrlNext.jalR15 = 1'b1;    // link is pc + 1.
                    end
                    opIn: begin
                        ctrlNext.busSel = busInPort;
                        ctrlNext.gra = 1'b1;
                        ctrlNext.rIn = 1'b1;
                    end
                    opOut: begin
                        ctrlNext.busSel = busReg;
                        ctrlNext.gra = 1'b1;
                        ctrlNext.outPortIn = 1'b1;
                    end
                    default: begin
                        ctrlNext.busSel = busReg;  // Rb into Y.
                        ctrlNext.grb = 1'b1;
                        ctrlNext.baOut = status.opcode inside {opLd, opLdi, opSt};
                        ctrlNext.yIn = 1'b1;
                    end
                endcase
            end
            sT4: begin
                if (isAluReg) begin
                    ctrlNext.busSel = busReg;
                    ctrlNext.grc = 1'b1;
                    ctrlNext.aluOp = regAluOp;
                    ctrlNext.zIn = 1'b1;
                end else if (status.opcode == opBr) begin
                    ctrlNext.busSel = busPc;
                    ctrlNext.yIn = 1'b1;
                end else if (status.opcode == opJal) begin
                    ctrlNext.busSel = busReg;
                    ctrlNext.gra = 1'b1;
                    ctrlNext.pcIn = 1'b1;
                end else begin
                    ctrlNext.busSel = busConst;    // base plus offset.
                    ctrlNext.aluOp = aluAdd;
                    ctrlNext.zIn = 1'b1;
                end
            end
            sT5: begin
                if (status.opcode == opBr) begin
                    ctrlNext.busSel = busConst;
                    ctrlNext.aluOp = aluAdd;
                    ctrlNext.zIn = 1'b1;
                end else if (status.opcode inside {opLd, opSt}) begin
                    ctrlNext.busSel = busZLow;
                    ctrlNext.marIn = 1'b1;         // effective address.
                end else begin
                    ctrlNext.busSel = busZLow;
                    ctrlNext.gra = 1'b1;
                    ctrlNext.rIn = 1'b1;
                end
            end
            sT6: begin
                if (status.opcode == opLd) begin
                    ctrlNext.memRead = 1'b1;
                end else if (status.opcode == opSt) begin
                    ctrlNext.busSel = busReg;
                    ctrlNext.gra = 1'b1;
                    ctrlNext.mdrIn = 1'b1;
                end else begin
                    ctrlNext.busSel = busZLow;
                    ctrlNext.pcIn = status.conFlag; // taken only on flag.
                end
            end
            sT7: begin
                if (status.opcode == opSt) begin
                    ctrlNext.memWrite = 1'b1;
                end else begin
                    ctrlNext.busSel = busMdr;
                    ctrlNext.gra = 1'b1;
                    ctrlNext.rIn = 1'b1;
                end
            end
            default: ctrlNext = '0;                // waits, halt.
        endcase
    end

    always_ff @(posedge clock) begin
        if (!rstN) begin
            state <= sReset;
            ctrl <= '0;
        end else begin
            state <= stateNext;
            ctrl <= ctrlNext;
        end
    end

    assign halted = (state == sHalt);

endmodule

// ==== rtl/miniSrcCore.sv ====
`timescale 1ns/10ps

module miniSrcCore (
    input  logic            clock,
    input  logic            rstN,
    input  logic            progWrite,
    input  srcPkg::memAddrT progAddr,
    input  srcPkg::wordT    progData,
    input  logic            inStrobe,
    input  srcPkg::wordT    inPortData,
    output srcPkg::wordT    outPortData,
    output logic            outValid,
    output logic            halted
);
    import srcPkg::*;

    ctrlT   ctrl;                                  // sequencer to datapath and memory.
    statusT status;
    wordT   busWord;
    wordT   mdrWord;

    controlSequencer u_controlSequencer (
        .clock  (clock),
        .rstN   (rstN),
        .status (status),
        .ctrl   (ctrl),
        .halted (halted)
    );

    miniSrcDatapath u_miniSrcDatapath (
        .clock       (clock),
        .rstN        (rstN),
        .ctrl        (ctrl),
        .mdrWord     (mdrWord),
        .busWord     (busWord),
        .status      (status),
        .inStrobe    (inStrobe),
        .inPortData  (inPortData),
        .outPortData (outPortData),
        .outValid    (outValid)
    );

    memoryInterface u_memoryInterface (
        .clock     (clock),
        .rstN      (rstN),
        .ctrl      (ctrl),
        .busWord   (busWord),
        .mdrWord   (mdrWord),
        .progWrite (progWrite),
        .progAddr  (progAddr),
        .progData  (progData)
    );

endmodule

// ==== bench/miniSrcCore_checker.sv ====
`timescale 1ns/10ps

module miniSrcCoreChecker (
    input logic         clock,
    input logic         rstN,
    input srcPkg::ctrlT ctrl,
    input logic         outValid,
    input logic         halted
);

    int assertFails = 0;                           // count of failed assertions.

    memExclusive: assert property (@(posedge clock) disable iff (!rstN)
        !(ctrl.memRead && ctrl.memWrite))
        else begin
            assertFails++;
            $error("memRead and memWrite asserted in the same cycle");
        end

    outStrobeOneCycle: assert property (@(posedge clock) disable iff (!rstN)
        outValid |=> !outValid)
        else begin
            assertFails++;
            $error("outValid held for more than one cycle");
        end

    // halt is only left through reset.
    haltSticky: assert property (@(posedge clock) disable iff (!rstN)
        halted |=> halted)
        else begin
            assertFails++;
            $error("halted dropped without reset");
        end

    quietWhenHalted: assert property (@(posedge clock) disable iff (!rstN)
        halted |-> !outValid)
        else begin
            assertFails++;
            $error("outValid seen while halted");
        end

endmodule

bind miniSrcCore miniSrcCoreChecker u_checker (
    .clock    (clock),
    .rstN     (rstN),
    .ctrl     (ctrl),                              // sequencer control word.
    .outValid (outValid),
    .halted   (halted)
);

// ==== bench/miniSrcTb.sv ====
`timescale 1ns/10ps

module miniSrcTb;
    import srcPkg::*;

    localparam int numPrograms = 5;
    localparam int maxInstrs = 40;
    localparam int maxInstrCycles = 12;            // ld takes fetch 5 plus execute 7.
    localparam int timeoutCycles = numPrograms * maxInstrs * maxInstrCycles + 600;

    logic    clock = 1'b0;
    logic    rstN;
    logic    progWrite;
    memAddrT progAddr;
    wordT    progData;
    logic    inStrobe;
    wordT    inPortData;
    wordT    outPortData;
    logic    outValid;
    logic    halted;

    wordT prog [$];                                // program image, word 0 first.
    wordT expQ [$];                                // expected out-port words.
    wordT outQ [$];                                // collected out-port words.
    int   cycleCount = 0;
    int   seed = 90;

    miniSrcCore u_miniSrcCore (
        .clock       (clock),
        .rstN        (rstN),
        .progWrite   (progWrite),
        .progAddr    (progAddr),
        .progData    (progData),
        .inStrobe    (inStrobe),
        .inPortData  (inPortData),
        .outPortData (outPortData),
        .outValid    (outValid),
        .halted      (halted)
    );

    always #5 clock = ~clock;                      // 10 ns period.

    always @(posedge clock) begin
        cycleCount++;
        if (cycleCount >= timeoutCycles) begin
            $display("timeout: programs did not finish within %0d cycles", timeoutCycles);
            $display("Finished with errors");
            $fatal(1);
        end
    end

    always @(negedge clock) begin
        if (outValid) begin
            outQ.push_back(outPortData);           // strobe lasts one cycle.
        end
        if (u_miniSrcCore.u_checker.assertFails != 0) begin
            $display("a bound assertion on the core failed");
            $display("Finished with errors");
            $fatal(1);
        end
    end

    // instruction encoders.
    function automatic wordT insR(opcodeT op, int ra, int rb, int rc);
        return {op, 4'(ra), 4'(rb), 4'(rc), 15'd0};
    endfunction

    function automatic wordT insI(opcodeT op, int ra, int rb, int c);
        return {op, 4'(ra), 4'(rb), 19'(c)};
    endfunction

    function automatic wordT insB(int ra, int c2, int c);
        return {opBr, 4'(ra), 2'b00, 2'(c2), 19'(c)};
    endfunction

    function automatic wordT insJ(opcodeT op, int ra);
        return {op, 4'(ra), 23'd0};
    endfunction

    function automatic logic branchTaken(wordT v, int c2);
        case (c2)
            0:       return v == 32'd0;
            1:       return v != 32'd0;
            2:       return !v[31];                // zero or positive.
            default: return v[31];
        endcase
    endfunction

    task automatic checkValue(string name, wordT actual, wordT expected);
        if (actual !== expected) begin
            $display("[FAIL] %s: got 0x%h, expected 0x%h", name, actual, expected);
            $display("Finished with errors");
            $fatal(1);
        end
    endtask

    task automatic emitOut(int ra, wordT expected);
        prog.push_back(insJ(opOut, ra));
        expQ.push_back(expected);
    endtask

    task automatic resetAndLoad();
        @(negedge clock);
        rstN = 1'b0;
        outQ.delete();
        repeat (4) @(negedge clock);
        for (int i = 0; i < prog.size(); i++) begin
            progWrite = 1'b1;                      // written on the next rising edge.
            progAddr = memAddrT'(i);
            progData = prog[i];
            @(negedge clock);
        end
        progWrite = 1'b0;
    endtask

    task automatic runToHalt();
        int doneCount;
        rstN = 1'b1;
        @(negedge clock);
        while (!halted) begin
            @(negedge clock);
        end
        doneCount = outQ.size();
        repeat (10) @(negedge clock);              // watch for late strobes.
        checkValue("outputs after halt", outQ.size(), doneCount);
        checkValue("halted", wordT'(halted), 32'd1);
        checkValue("output count", outQ.size(), expQ.size());
        for (int i = 0; i < expQ.size(); i++) begin
            checkValue($sformatf("outPortData[%0d]", i), outQ[i], expQ[i]);
        end
        prog.delete();
        expQ.delete();
    endtask

    task automatic testArithmetic();
        wordT a;
        wordT b;
        wordT m1;
        a = wordT'(100000);
        b = wordT'(-54321);
        m1 = wordT'(-1);
        prog.push_back(insI(opLdi, 1, 0, 100000));
        prog.push_back(insI(opLdi, 2, 0, -54321));
        prog.push_back(insI(opLdi, 9, 0, -1));
        prog.push_back(insR(opAdd, 3, 1, 2));
        emitOut(3, a + b);
        prog.push_back(insR(opSub, 4, 2, 1));
        emitOut(4, b - a);
        prog.push_back(insR(opAnd, 5, 1, 2));
        emitOut(5, a & b);
        prog.push_back(insR(opOr, 6, 1, 2));
        emitOut(6, a | b);
        prog.push_back(insI(opAddi, 7, 3, -200000));
        emitOut(7, a + b + wordT'(-200000));
        prog.push_back(insI(opAddi, 8, 2, 262143)); // largest positive constant.
        emitOut(8, b + wordT'(262143));
        prog.push_back(insR(opAdd, 10, 9, 9));
        emitOut(10, m1 + m1);                      // wraps past 2^32.
        prog.push_back(insR(opSub, 11, 0, 9));
        emitOut(11, 32'd0 - m1);
        prog.push_back(insI(opLdi, 12, 1, 5));     // ldi with a nonzero base.
        emitOut(12, a + 32'd5);
        prog.push_back(insJ(opHalt, 0));
        resetAndLoad();
        runToHalt();
    endtask

    task automatic testMemory();
        prog.push_back(insI(opLdi, 0, 0, 999));    // R0 holds 999 but reads zero as base.
        prog.push_back(insI(opLdi, 1, 0, 300));
        prog.push_back(insI(opLdi, 5, 0, 350));
        prog.push_back(insI(opLdi, 2, 0, 77777));
        prog.push_back(insI(opLdi, 3, 0, -12345));
        prog.push_back(insI(opLdi, 4, 0, 200000));
        prog.push_back(insI(opSt, 2, 1, 0));       // mem[300].
        prog.push_back(insI(opSt, 3, 1, 5));       // mem[305].
        prog.push_back(insI(opSt, 4, 1, 20));      // mem[320].
        prog.push_back(insI(opSt, 3, 0, 330));     // mem[330] by absolute address.
        prog.push_back(insI(opSt, 2, 5, -10));     // mem[340] by negative offset.
        prog.push_back(insI(opLd, 6, 1, 0));
        emitOut(6, wordT'(77777));
        prog.push_back(insI(opLd, 7, 1, 5));
        emitOut(7, wordT'(-12345));
        prog.push_back(insI(opLd, 8, 0, 320));
        emitOut(8, wordT'(200000));
        prog.push_back(insI(opLd, 10, 1, 30));
        emitOut(10, wordT'(-12345));
        prog.push_back(insI(opLd, 11, 5, -10));
        emitOut(11, wordT'(77777));
        emitOut(0, wordT'(999));                   // plain read sees contents.
        prog.push_back(insJ(opHalt, 0));
        resetAndLoad();
        runToHalt();
    endtask

    task automatic testSubroutine();
        int firstJal;
        int secondJal;
        prog.push_back(insI(opLdi, 2, 0, 9));      // routine entry at word 9.
        firstJal = prog.size();
        prog.push_back(insJ(opJal, 2));
        expQ.push_back(wordT'(firstJal + 1));      // link reported by the routine.
        prog.push_back(insI(opLdi, 3, 0, 'h5A));
        emitOut(3, 32'h5A);
        secondJal = prog.size();
        prog.push_back(insJ(opJal, 2));
        expQ.push_back(wordT'(secondJal + 1));
        prog.push_back(insI(opLdi, 4, 0, 'hA5));
        emitOut(4, 32'hA5);
        prog.push_back(insJ(opHalt, 0));
        prog.push_back(insJ(opNop, 0));            // pad.
        prog.push_back(insJ(opOut, 15));           // routine body.
        prog.push_back(insJ(opJr, 15));
        resetAndLoad();
        runToHalt();
    endtask

    task automatic testBranches();
        int caseReg [8] = '{1, 2, 2, 1, 2, 3, 3, 2};
        int regVal [4] = '{0, 0, 5, -7};
        int c2;
        prog.push_back(insI(opLdi, 1, 0, 0));
        prog.push_back(insI(opLdi, 2, 0, 5));
        prog.push_back(insI(opLdi, 3, 0, -7));
        for (int k = 0; k < 8; k++) begin
            c2 = k / 2;                            // each condition twice.
            prog.push_back(insI(opLdi, 10, 0, 'h100 + k));
            prog.push_back(insB(caseReg[k], c2, 1));
            prog.push_back(insI(opLdi, 10, 0, 'h200 + k));
            if (branchTaken(wordT'(regVal[caseReg[k]]), c2)) begin
                emitOut(10, wordT'('h100 + k));
            end else begin
                emitOut(10, wordT'('h200 + k));
            end
        end
        prog.push_back(insI(opLdi, 5, 0, 3));
        prog.push_back(insI(opAddi, 5, 5, -1));    // countdown loop.
        prog.push_back(insB(5, 1, -2));            // back while nonzero.
        emitOut(5, 32'd0);
        prog.push_back(insJ(opHalt, 0));
        resetAndLoad();
        runToHalt();
    endtask

    task automatic testInputHalt();
        wordT firstIn;
        wordT secondIn;
        firstIn = $random(seed);
        secondIn = $random(seed);
        prog.push_back(insJ(opIn, 1));
        emitOut(1, secondIn);                      // later strobe overwrites.
        prog.push_back(insI(opAddi, 2, 1, 1));
        emitOut(2, secondIn + 32'd1);
        prog.push_back(insJ(opHalt, 0));
        prog.push_back(insJ(opOut, 1));            // never reached.
        resetAndLoad();
        inPortData = firstIn;
        inStrobe = 1'b1;
        @(negedge clock);
        inPortData = secondIn;
        @(negedge clock);
        inStrobe = 1'b0;
        runToHalt();
    endtask

    initial begin
        rstN = 1'b0;
        progWrite = 1'b0;
        progAddr = '0;
        progData = '0;
        inStrobe = 1'b0;
        inPortData = '0;
        repeat (4) @(negedge clock);
        testArithmetic();
        testMemory();
        testSubroutine();
        testBranches();
        testInputHalt();
        if (u_miniSrcCore.u_checker.assertFails == 0) begin
            $display("Finished with no errors");
            $finish;
        end else begin
            $display("a bound assertion on the core failed");
            $display("Finished with errors");
            $fatal(1);
        end
    end

endmodule

// ==== filelist.f ====
rtl/srcPkg.sv
rtl/registerFile.sv
rtl/aluUnit.sv
rtl/memoryInterface.sv
rtl/miniSrcDatapath.sv
rtl/controlSequencer.sv
rtl/miniSrcCore.sv
bench/miniSrcCore_checker.sv
bench/miniSrcTb.sv

// ==== Bender.yml ====
package:
  name: mini_src_core

sources:
  - rtl/srcPkg.sv
  - rtl/registerFile.sv
  - rtl/aluUnit.sv
  - rtl/memoryInterface.sv
  - rtl/miniSrcDatapath.sv
  - rtl/controlSequencer.sv
  - rtl/miniSrcCore.sv
  - target: simulation
    files:
      - bench/miniSrcCore_checker.sv
      - bench/miniSrcTb.sv
